//--- Makefile
SRCS := $(shell grep -v '^+' build.f) rtl/pcw_defines.svh

.PHONY: run clean

run: obj_dir/Vpcw_ctrl_tb
	./obj_dir/Vpcw_ctrl_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED"

obj_dir/Vpcw_ctrl_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module pcw_ctrl_tb -o Vpcw_ctrl_tb

clean:
	rm -rf obj_dir

//--- build.f
+incdir+rtl
rtl/pcw_pkg.sv
rtl/port_decode.sv
rtl/system_regs.sv
rtl/page_mapper.sv
rtl/timer_int_ctrl.sv
rtl/pcw_ctrl_top.sv
test/pcw_ctrl_assertions.sv
test/pcw_ctrl_tb.sv

//--- rtl/page_mapper.sv
`timescale 1ns/100ps

module page_mapper
    import pcw_pkg::*;
(
    input  page_regs_t regs,
    input  cpu_addr_t  addr,
    input  logic       mem_wr,     // Write selects CPC write bank
    input  mem_size_e  mem_size,
    output ram_addr_t  ram_addr
);

    logic [1:0]  slot;       // 16K window of the CPU space
    logic [13:0] offset;     // Address within the page
    data_t       page_reg;   // Register for this slot
    bank_t       pcw_bank;
    logic [2:0]  cpc_bank;
    logic        read_lock;

    assign slot   = addr[15:14];
    assign offset = addr[13:0];

    always_comb begin
        case (slot)
            2'd0:    page_reg = regs.bank0;
            2'd1:    page_reg = regs.bank1;
            2'd2:    page_reg = regs.bank2;
            default: page_reg = regs.bank3;
        endcase
    end

    // Page number wraps at the installed size
    always_comb begin
        case (mem_size)
            MEM_256K: pcw_bank = {3'b000, page_reg[3:0]};   // 16 pages
            MEM_512K: pcw_bank = {2'b00, page_reg[4:0]};
            MEM_1M:   pcw_bank = {1'b0, page_reg[5:0]};
            MEM_2M:   pcw_bank = page_reg[6:0];             // All 128 pages
            default:  pcw_bank = page_reg[6:0];
        endcase
    end

    // Lock bit 4+slot, index {1, slot} is the same thing
    assign read_lock = regs.lock[{1'b1, slot}];

    // CPC mode
    // Writes always go to bits 2..0
    // Unlocked reads come from bits 6..4
    assign cpc_bank = (mem_wr || read_lock) ? page_reg[2:0] : page_reg[6:4];

    // Bit 7 of the page register picks PCW mode
    assign ram_addr = page_reg[7] ? {pcw_bank, offset}
                                  : {4'b0000, cpc_bank, offset};

endmodule

//--- rtl/pcw_ctrl_top.sv
`timescale 1ns/100ps

module pcw_ctrl_top
    import pcw_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  cpu_bus_t    bus,         // CPU side
    input  mem_size_e   mem_size,
    input  logic        vid_timer,
    input  logic        fdc_int,
    input  logic        iff1,
    input  logic        vblank,
    input  logic        ntsc,
    output ram_addr_t   ram_addr,
    output data_t       rdata,       // Status byte or idle bus
    output page_regs_t  regs,        // Register state readback
    output ctrl_flags_t flags,
    output miss_t       miss,
    output logic        nmi_n,
    output logic        int_n
);

    port_strobe_t strobe;

    port_decode i_port_decode (
        .bus    (bus),
        .strobe (strobe)
    );

    system_regs i_system_regs (
        .clk_sys (clk_sys),
        .reset   (reset),
        .strobe  (strobe),
        .wdata   (bus.wdata),
        .regs    (regs),
        .flags   (flags)
    );

    page_mapper i_page_mapper (
        .regs     (regs),
        .addr     (bus.addr),
        .mem_wr   (bus.mem_wr),
        .mem_size (mem_size),
        .ram_addr (ram_addr)
    );

    timer_int_ctrl i_timer_int_ctrl (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .flags     (flags),
        .cmd       (strobe.cmd),
        .status_rd (strobe.status_rd),
        .timer_clr (strobe.timer_clr),
        .vid_timer (vid_timer),
        .fdc_int   (fdc_int),
        .iff1      (iff1),
        .vblank    (vblank),
        .ntsc      (ntsc),
        .miss      (miss),
        .nmi_n     (nmi_n),
        .int_n     (int_n),
        .rdata     (rdata)
    );

endmodule

//--- rtl/pcw_defines.svh
`ifndef PCW_DEFINES_SVH
`define PCW_DEFINES_SVH

// I/O ports, low address byte only
`define PCW_PORT_BANK0   8'hF0   // Slot 0 page, 0000-3FFF
`define PCW_PORT_BANK1   8'hF1   // Slot 1 page, 4000-7FFF
`define PCW_PORT_BANK2   8'hF2   // Slot 2 page, 8000-BFFF
`define PCW_PORT_BANK3   8'hF3   // Slot 3 page, C000-FFFF
`define PCW_PORT_LOCK    8'hF4   // CPC read lock on write, timer clear on read
`define PCW_PORT_ROLLER  8'hF5   // Roller RAM address
`define PCW_PORT_SCROLL  8'hF6   // Vertical scroll
`define PCW_PORT_MODE    8'hF7   // Inverse and display enable
`define PCW_PORT_SYSCTL  8'hF8   // System Control write, status read

// Register values after reset
`define PCW_RST_BANK0    8'h80
`define PCW_RST_BANK1    8'h81
`define PCW_RST_BANK2    8'h82
`define PCW_RST_BANK3    8'h83
`define PCW_RST_LOCK     8'hF1
`define PCW_RST_MODE     8'h80   // Inverse set, display off

// Timer interrupt
`define PCW_CLEAR_CYCLES 32      // Delay from F4 read to timer clear
`define PCW_MISS_MAX     15      // Miss counter stops here

// Value seen on reads of ports not decoded here
`define PCW_IDLE_BUS     8'hFF

`endif

//--- rtl/pcw_pkg.sv
package pcw_pkg;

    typedef logic [15:0] cpu_addr_t;   // Z80 address
    typedef logic [7:0]  data_t;       // Bus data
    typedef logic [20:0] ram_addr_t;   // 2MB physical RAM
    typedef logic [6:0]  bank_t;       // 16K page number
    typedef logic [3:0]  miss_t;       // Missed timer ticks

    // Installed memory
    typedef enum logic [1:0] {
        MEM_256K = 2'd0,
        MEM_512K = 2'd1,
        MEM_1M   = 2'd2,
        MEM_2M   = 2'd3
    } mem_size_e;

    // Decoded System Control commands
    typedef enum logic [3:0] {
        CMD_NONE, CMD_DISK_NMI, CMD_DISK_INT, CMD_DISK_OFF, CMD_TC_SET,
        CMD_TC_CLR, CMD_MOTOR_ON, CMD_MOTOR_OFF, CMD_SPK_ON, CMD_SPK_OFF
    } sys_cmd_e;

    typedef enum logic {CLR_IDLE, CLR_COUNT} clr_state_e;

    typedef struct packed {
        cpu_addr_t addr;
        data_t     wdata;
        logic      io_rd;     // I/O read level
        logic      io_wr;     // I/O write level
        logic      mem_wr;    // Memory write, selects CPC write bank
    } cpu_bus_t;

    typedef struct packed {
        logic [3:0] bank_wr;   // One per slot register
        logic       lock_wr;
        logic       roller_wr;
        logic       scroll_wr;
        logic       mode_wr;
        logic       status_rd;  // F8 or F4 read
        logic       timer_clr;  // F4 read only
        sys_cmd_e   cmd;
    } port_strobe_t;

    typedef struct packed {
        data_t bank0, bank1, bank2, bank3, lock, roller, scroll, mode;
    } page_regs_t;

    typedef struct packed {
        logic disk_to_nmi;
        logic disk_to_int;
        logic tc;               // FDC terminal count
        logic motor;
        logic speaker_enable;
    } ctrl_flags_t;

endpackage

//--- rtl/port_decode.sv
`timescale 1ns/100ps
`include "pcw_defines.svh"

module port_decode
    import pcw_pkg::*;
(
    input  cpu_bus_t     bus,
    output port_strobe_t strobe
);

    logic [7:0] port;     // Only the low address byte takes part
    logic       sys_wr;   // Write to System Control

    assign port   = bus.addr[7:0];
    assign sys_wr = bus.io_wr && (port == `PCW_PORT_SYSCTL);

    // Register write strobes
    always_comb begin
        strobe.bank_wr[0] = bus.io_wr && (port == `PCW_PORT_BANK0);
        strobe.bank_wr[1] = bus.io_wr && (port == `PCW_PORT_BANK1);
        strobe.bank_wr[2] = bus.io_wr && (port == `PCW_PORT_BANK2);
        strobe.bank_wr[3] = bus.io_wr && (port == `PCW_PORT_BANK3);
        strobe.lock_wr    = bus.io_wr && (port == `PCW_PORT_LOCK);
        strobe.roller_wr  = bus.io_wr && (port == `PCW_PORT_ROLLER);
        strobe.scroll_wr  = bus.io_wr && (port == `PCW_PORT_SCROLL);
        strobe.mode_wr    = bus.io_wr && (port == `PCW_PORT_MODE);
    end

    // Status is readable at both F8 and F4
    assign strobe.status_rd = bus.io_rd &&
                              ((port == `PCW_PORT_SYSCTL) || (port == `PCW_PORT_LOCK));
    // F4 read also acknowledges the timer
    assign strobe.timer_clr = bus.io_rd && (port == `PCW_PORT_LOCK);

    // System Control command in data bits 3..0
    always_comb begin
        strobe.cmd = CMD_NONE;
        if (sys_wr) begin
            case (bus.wdata[3:0])
                4'd2:    strobe.cmd = CMD_DISK_NMI;
                4'd3:    strobe.cmd = CMD_DISK_INT;
                4'd4:    strobe.cmd = CMD_DISK_OFF;   // Disconnect disk interrupt
                4'd5:    strobe.cmd = CMD_TC_SET;
                4'd6:    strobe.cmd = CMD_TC_CLR;
                4'd9:    strobe.cmd = CMD_MOTOR_ON;
                4'd10:   strobe.cmd = CMD_MOTOR_OFF;
                4'd11:   strobe.cmd = CMD_SPK_ON;
                4'd12:   strobe.cmd = CMD_SPK_OFF;
                // 0 ends bootstrap, 1 is system reset
                // Neither applies here, nor do 7, 8, 13 to 15
                default: strobe.cmd = CMD_NONE;
            endcase
        end
    end

endmodule

//--- rtl/system_regs.sv
`timescale 1ns/100ps
`include "pcw_defines.svh"

module system_regs
    import pcw_pkg::*;
(
    input  logic         clk_sys,
    input  logic         reset,
    input  port_strobe_t strobe,
    input  data_t        wdata,    // Bus write data
    output page_regs_t   regs,
    output ctrl_flags_t  flags
);

    // Page and mode registers, F0 to F7
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            regs.bank0  <= `PCW_RST_BANK0;    // PCW mode, pages 0 to 3
            regs.bank1  <= `PCW_RST_BANK1;
            regs.bank2  <= `PCW_RST_BANK2;
            regs.bank3  <= `PCW_RST_BANK3;
            regs.lock   <= `PCW_RST_LOCK;
            regs.roller <= '0;
            regs.scroll <= '0;
            regs.mode   <= `PCW_RST_MODE;
        end else begin
            if (strobe.bank_wr[0]) regs.bank0 <= wdata;
            if (strobe.bank_wr[1]) regs.bank1 <= wdata;
            if (strobe.bank_wr[2]) regs.bank2 <= wdata;
            if (strobe.bank_wr[3]) regs.bank3 <= wdata;
            if (strobe.lock_wr) regs.lock <= wdata;       // Bits 7..4 lock slots 3..0
            if (strobe.roller_wr) regs.roller <= wdata;
            if (strobe.scroll_wr) regs.scroll <= wdata;
            if (strobe.mode_wr) regs.mode <= wdata;
        end
    end

    // System Control flags
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            flags <= '0;
        end else begin
            case (strobe.cmd)
                CMD_DISK_NMI: begin
                    flags.disk_to_nmi <= 1'b1;
                    flags.disk_to_int <= 1'b0;   // Only one route at a time
                end
                CMD_DISK_INT: begin
                    flags.disk_to_nmi <= 1'b0;
                    flags.disk_to_int <= 1'b1;
                end
                CMD_DISK_OFF: begin
                    // Disk interrupt goes nowhere
                    flags.disk_to_nmi <= 1'b0;
                    flags.disk_to_int <= 1'b0;
                end
                CMD_TC_SET:    flags.tc <= 1'b1;
                CMD_TC_CLR:    flags.tc <= 1'b0;
                CMD_MOTOR_ON:  flags.motor <= 1'b1;
                CMD_MOTOR_OFF: flags.motor <= 1'b0;
                CMD_SPK_ON:    flags.speaker_enable <= 1'b1;   // Bleeper on
                CMD_SPK_OFF:   flags.speaker_enable <= 1'b0;
                default: begin
                    // No command this cycle
                end
            endcase
        end
    end

endmodule

//--- rtl/timer_int_ctrl.sv
`timescale 1ns/100ps
`include "pcw_defines.svh"

module timer_int_ctrl
    import pcw_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  ctrl_flags_t flags,
    input  sys_cmd_e    cmd,
    input  logic        status_rd,
    input  logic        timer_clr,   // F4 read
    input  logic        vid_timer,   // 300 Hz tick from video
    input  logic        fdc_int,
    input  logic        iff1,        // CPU interrupts enabled
    input  logic        vblank,
    input  logic        ntsc,
    output miss_t       miss,
    output logic        nmi_n,
    output logic        int_n,
    output data_t       rdata
);

    localparam int CLR_W = $clog2(`PCW_CLEAR_CYCLES);

    logic             vid_q;
    logic             fdc_q;
    logic             timer_pe;
    logic             fdc_pe;
    logic             fdc_ne;
    logic             fdc_latch;    // FDC status bit in F8
    logic             nmi_flag;     // Pending disk NMI
    logic             timer_line;
    logic             int_line;     // Disk INT
    logic             nmi_line;
    logic             clr_done;
    clr_state_e       clr_state;
    logic [CLR_W-1:0] clr_count;

    // Edge detect on the registered inputs
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vid_q <= 1'b0;
            fdc_q <= 1'b0;
        end else begin
            vid_q <= vid_timer;
            fdc_q <= fdc_int;
        end
    end

    assign timer_pe = vid_timer & ~vid_q;
    assign fdc_pe   = fdc_int & ~fdc_q;
    assign fdc_ne   = ~fdc_int & fdc_q;

    // FDC latch follows the interrupt, NMI flag waits for software
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            fdc_latch <= 1'b0;
            nmi_flag  <= 1'b0;
        end else begin
            if (fdc_pe) begin
                fdc_latch <= 1'b1;
                if (flags.disk_to_nmi) nmi_flag <= 1'b1;
            end else if (fdc_ne) begin
                fdc_latch <= 1'b0;
            end
            if (cmd == CMD_DISK_INT || cmd == CMD_DISK_OFF) nmi_flag <= 1'b0;
        end
    end

    // Delayed timer acknowledge, a new F4 read restarts it
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            clr_state <= CLR_IDLE;
            clr_count <= '0;
        end else if (timer_clr) begin
            clr_state <= CLR_COUNT;
            clr_count <= '0;
        end else if (clr_state == CLR_COUNT) begin
            if (clr_done) clr_state <= CLR_IDLE;
            else clr_count <= clr_count + 1'b1;
        end
    end

    assign clr_done = (clr_state == CLR_COUNT) &&
                      (clr_count == CLR_W'(`PCW_CLEAR_CYCLES - 1));   // 32nd edge

    // Miss counter and interrupt lines, updated on each tick
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            miss       <= '0;
            timer_line <= 1'b0;
            nmi_line   <= 1'b0;
            int_line   <= 1'b0;
        end else begin
            if (timer_pe) begin
                if (miss != miss_t'(`PCW_MISS_MAX)) miss <= miss + 1'b1;
                timer_line <= iff1;
                nmi_line   <= nmi_flag;   // NMI raised or held on the tick
                int_line   <= fdc_latch & flags.disk_to_int & iff1;
            end
            if (clr_done) begin
                miss       <= '0;
                timer_line <= 1'b0;
            end
            if (cmd == CMD_DISK_OFF) int_line <= 1'b0;
        end
    end

    assign nmi_n = ~nmi_line;
    assign int_n = nmi_line ? 1'b1 : ~(int_line | timer_line);   // Held off while NMI pending

    assign rdata = status_rd ? {1'b0, vblank, fdc_latch, ~ntsc, miss} : `PCW_IDLE_BUS;

endmodule

//--- test/pcw_ctrl_assertions.sv
`timescale 1ns/100ps

module pcw_ctrl_assertions
    import pcw_pkg::*;
(
    input logic        clk_sys,
    input logic        reset,
    input logic        nmi_n,
    input logic        int_n,
    input miss_t       miss,
    input ctrl_flags_t flags,
    input clr_state_e  clr_state   // Timer clear FSM inside timer_int_ctrl
);

    // NMI holds INT off
    a_nmi_masks_int: assert property (@(posedge clk_sys) disable iff (reset)
        !nmi_n |-> int_n)
        else $error("int_n low while nmi_n low");

    // Saturated count only drops through the delayed clear
    a_miss_clear: assert property (@(posedge clk_sys) disable iff (reset)
        ($past(miss) == 4'd15 && miss == 4'd0) |-> $past(clr_state) == CLR_COUNT)
        else $error("miss went from 15 to 0 without a clear");

    a_one_route: assert property (@(posedge clk_sys) disable iff (reset)
        !(flags.disk_to_nmi && flags.disk_to_int))
        else $error("disk interrupt routed to NMI and INT at once");

endmodule

bind pcw_ctrl_top pcw_ctrl_assertions i_pcw_ctrl_assertions (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .nmi_n     (nmi_n),
    .int_n     (int_n),
    .miss      (miss),
    .flags     (flags),
    .clr_state (i_timer_int_ctrl.clr_state)
);

//--- test/pcw_ctrl_tb.sv
`timescale 1ns/100ps
`include "pcw_defines.svh"

module pcw_ctrl_tb
    import pcw_pkg::*;
();

    typedef struct {
        cpu_bus_t    bus;
        mem_size_e   msz;
        logic        vid, fdc, iff1, vblank, ntsc;
        ram_addr_t   exp_addr;    // Combinational, same cycle
        data_t       exp_data;
        ctrl_flags_t exp_flags;   // Registered, after the sampling edge
        page_regs_t  exp_regs;
        miss_t       exp_miss;
        logic        exp_nmi_n, exp_int_n;
    } row_t;

    logic clk_sys, reset, vid_timer, fdc_int, iff1, vblank, ntsc, nmi_n, int_n;
    cpu_bus_t    bus;
    mem_size_e   mem_size;
    ram_addr_t   ram_addr;
    data_t       rdata;
    page_regs_t  regs;
    ctrl_flags_t flags;
    miss_t       miss;
    row_t        rows[$];
    logic [15:0] lfsr = 16'd31;
    int          cycles = 0;
    int          limit = 1000;
    // Reference state kept by the table builder
    data_t       m_bank[4] = '{8'h80, 8'h81, 8'h82, 8'h83};
    data_t       m_lock = 8'hF1;
    data_t       m_extra[3] = '{8'h00, 8'h00, 8'h80};   // Roller, scroll and mode
    ctrl_flags_t m_flags = '0;
    int          m_miss = 0, m_clr = 0;
    logic        m_latch = 0, m_nmi_flag = 0, m_nmi_line = 0, m_int_line = 0, m_timer_line = 0;
    logic        m_vid = 0, m_fdc = 0;
    mem_size_e   cur_msz = MEM_256K;
    logic        cur_vid = 0, cur_fdc = 0, cur_iff1 = 0, cur_vblank = 0, cur_ntsc = 0;

    pcw_ctrl_top i_pcw_ctrl_top (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles > limit) fail_run("Timeout, the table did not finish in time");
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic ram_addr_t expect_ram(cpu_addr_t a, logic wr);
        data_t pg;
        pg = m_bank[a[15:14]];
        if (pg[7]) return ram_addr_t'({pg[6:0] & 7'((1 << (4 + cur_msz)) - 1), a[13:0]});
        if (wr || m_lock[4 + a[15:14]]) return ram_addr_t'({pg[2:0], a[13:0]});
        return ram_addr_t'({pg[6:4], a[13:0]});
    endfunction

    task automatic check_addr(ram_addr_t got, ram_addr_t exp, int i);
        if (got !== exp) fail_run($sformatf("CHECK FAILED at %0t: row %0d ram_addr %h, expected %h",
                                            $time, i, got, exp));
    endtask
    task automatic check_data(data_t got, data_t exp, int i);
        if (got !== exp) fail_run($sformatf("CHECK FAILED at %0t: row %0d rdata %h, expected %h",
                                            $time, i, got, exp));
    endtask
    task automatic check_flags(ctrl_flags_t got, ctrl_flags_t exp, int i);
        if (got !== exp) fail_run($sformatf("CHECK FAILED at %0t: row %0d flags %b, expected %b",
                                            $time, i, got, exp));
    endtask
    task automatic check_regs(page_regs_t got, page_regs_t exp, int i);
        if (got !== exp) fail_run($sformatf("CHECK FAILED at %0t: row %0d regs %h, expected %h",
                                            $time, i, got, exp));
    endtask
    task automatic check_miss(miss_t got, miss_t exp, int i);
        if (got !== exp) fail_run($sformatf("CHECK FAILED at %0t: row %0d miss %0d, expected %0d",
                                            $time, i, got, exp));
    endtask
    task automatic check_lines(logic n_got, logic i_got, logic n_exp, logic i_exp, int i);
        if (n_got !== n_exp || i_got !== i_exp)
            fail_run($sformatf("CHECK FAILED at %0t: row %0d nmi_n/int_n %b%b, expected %b%b",
                               $time, i, n_got, i_got, n_exp, i_exp));
    endtask

    // Appends one row and steps the reference model over its sampling edge
    task automatic add_row(input cpu_addr_t a, input data_t d, input logic rd, wr, mwr);
        row_t r;
        logic tpe, sc, old_latch, old_nmi;
        ctrl_flags_t old_f;
        r.bus = '{addr: a, wdata: d, io_rd: rd, io_wr: wr, mem_wr: mwr};
        r.msz = cur_msz;
        r.vid = cur_vid;
        r.fdc = cur_fdc;
        r.iff1 = cur_iff1;
        r.vblank = cur_vblank;
        r.ntsc = cur_ntsc;
        r.exp_addr = expect_ram(a, mwr);
        r.exp_data = (rd && (a[7:0] == `PCW_PORT_SYSCTL || a[7:0] == `PCW_PORT_LOCK)) ?
                     {1'b0, cur_vblank, m_latch, ~cur_ntsc, 4'(m_miss)} : 8'hFF;
        tpe = cur_vid & ~m_vid;
        sc = wr && a[7:0] == `PCW_PORT_SYSCTL;
        old_latch = m_latch;
        old_nmi = m_nmi_flag;
        old_f = m_flags;
        if (cur_fdc & ~m_fdc) begin
            m_latch = 1'b1;
            if (old_f.disk_to_nmi) m_nmi_flag = 1'b1;
        end else if (~cur_fdc & m_fdc) m_latch = 1'b0;
        if (sc && (d[3:0] == 3 || d[3:0] == 4)) m_nmi_flag = 1'b0;
        if (tpe) begin
            if (m_miss < 15) m_miss++;
            m_timer_line = cur_iff1;
            m_nmi_line = old_nmi;
            m_int_line = old_latch & old_f.disk_to_int & cur_iff1;
        end
        if (m_clr > 0) begin
            m_clr--;
            if (m_clr == 0) {m_miss, m_timer_line} = '0;   // 32nd edge after the F4 read
        end
        if (rd && a[7:0] == `PCW_PORT_LOCK) m_clr = 32;
        if (sc) begin
            case (d[3:0])
                2:  {m_flags.disk_to_nmi, m_flags.disk_to_int} = 2'b10;
                3:  {m_flags.disk_to_nmi, m_flags.disk_to_int} = 2'b01;
                4:  {m_flags.disk_to_nmi, m_flags.disk_to_int, m_int_line} = 3'b000;
                5:  m_flags.tc = 1'b1;
                6:  m_flags.tc = 1'b0;
                9:  m_flags.motor = 1'b1;
                10: m_flags.motor = 1'b0;
                11: m_flags.speaker_enable = 1'b1;
                12: m_flags.speaker_enable = 1'b0;
                default: ;
            endcase
        end
        if (wr && a[7:0] >= 8'hF0 && a[7:0] <= 8'hF3) m_bank[a[1:0]] = d;
        if (wr && a[7:0] == `PCW_PORT_LOCK) m_lock = d;
        if (wr && a[7:0] >= 8'hF5 && a[7:0] <= 8'hF7) m_extra[2'(a[7:0] - 8'hF5)] = d;
        {m_vid, m_fdc} = {cur_vid, cur_fdc};
        r.exp_flags = m_flags;
        r.exp_regs = {m_bank[0], m_bank[1], m_bank[2], m_bank[3], m_lock,
                      m_extra[0], m_extra[1], m_extra[2]};
        r.exp_miss = 4'(m_miss);
        r.exp_nmi_n = ~m_nmi_line;
        r.exp_int_n = m_nmi_line ? 1'b1 : ~(m_int_line | m_timer_line);
        rows.push_back(r);
    endtask

    task automatic timer_pulse();
        cur_vid = 1'b1;
        add_row(16'h0000, 8'h00, 0, 0, 0);
        cur_vid = 1'b0;
        add_row(16'h0000, 8'h00, 0, 0, 0);
    endtask

    initial begin
        logic [31:0] v, w;
        {reset, vid_timer, fdc_int, iff1, vblank, ntsc} <= 6'b100000;
        bus <= '0;
        mem_size <= MEM_256K;
        v = rand_bits(14);
        add_row({2'b00, v[13:0]}, 8'h00, 0, 0, 0);   // Slot 0 after reset
        for (int p = 5; p < 8; p++) begin            // Roller, scroll and mode readback
            v = rand_bits(8);
            add_row({8'h00, 8'hF0 + 8'(p)}, v[7:0], 0, 1, 0);
        end
        for (int s = 0; s < 4; s++) begin            // PCW paging, every size
            cur_msz = mem_size_e'(s);
            for (int b = 0; b < 4; b++) begin
                v = rand_bits(8);
                add_row({8'h00, 8'hF0 + 8'(b)}, 8'h80 | v[7:0], 0, 1, 0);
            end
            for (int b = 0; b < 4; b++) begin
                v = rand_bits(14);
                add_row({2'(b), v[13:0]}, 8'h00, 0, 0, 0);
            end
        end
        for (int k = 0; k < 2; k++) begin            // CPC paging, two lock values
            for (int b = 0; b < 4; b++) begin
                v = rand_bits(7);
                add_row({8'h00, 8'hF0 + 8'(b)}, {1'b0, v[6:0]}, 0, 1, 0);
            end
            v = rand_bits(4);
            add_row({8'h00, `PCW_PORT_LOCK}, {v[3:0], 4'h0}, 0, 1, 0);
            for (int b = 0; b < 4; b++) begin
                v = rand_bits(14);
                add_row({2'(b), v[13:0]}, 8'h00, 0, 0, 0);
                add_row({2'(b), v[13:0]}, 8'h00, 0, 0, 1);
            end
        end
        for (int n = 31; n >= 0; n--) begin          // Every System Control nibble, twice down
            w = rand_bits(4);
            add_row({8'h00, `PCW_PORT_SYSCTL}, {w[3:0], 4'(n)}, 0, 1, 0);
        end
        {cur_iff1, cur_vblank, cur_ntsc} = 3'b110;
        repeat (17) timer_pulse();
        add_row({8'h00, `PCW_PORT_SYSCTL}, 8'h00, 1, 0, 0);
        add_row({8'h00, `PCW_PORT_LOCK}, 8'h00, 1, 0, 0);
        repeat (33) add_row(16'h0000, 8'h00, 0, 0, 0);
        add_row({8'h00, `PCW_PORT_SYSCTL}, 8'h02, 0, 1, 0);   // Disk to NMI
        cur_fdc = 1'b1;
        add_row(16'h0000, 8'h00, 0, 0, 0);
        timer_pulse();
        add_row({8'h00, `PCW_PORT_SYSCTL}, 8'h03, 0, 1, 0);   // Disk to INT
        timer_pulse();
        add_row({8'h00, `PCW_PORT_LOCK}, 8'h00, 1, 0, 0);     // Timer line off, INT line alone
        repeat (32) add_row(16'h0000, 8'h00, 0, 0, 0);
        cur_fdc = 1'b0;
        add_row({8'h00, `PCW_PORT_SYSCTL}, 8'h04, 0, 1, 0);
        {cur_vblank, cur_ntsc} = 2'b01;
        add_row({8'h00, `PCW_PORT_SYSCTL}, 8'h00, 1, 0, 0);   // Latch dropped with fdc_int
        limit = rows.size() * 40 + 200;
        repeat (5) @(posedge clk_sys);
        reset <= 1'b0;
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk_sys);
            if (i < rows.size()) begin
                bus <= rows[i].bus;
                mem_size <= rows[i].msz;
                {vid_timer, fdc_int, iff1, vblank, ntsc} <=
                    {rows[i].vid, rows[i].fdc, rows[i].iff1, rows[i].vblank, rows[i].ntsc};
            end else begin
                bus <= '0;
            end
            @(negedge clk_sys);
            if (i < rows.size()) begin
                check_addr(ram_addr, rows[i].exp_addr, i);
                check_data(rdata, rows[i].exp_data, i);
            end
            if (i > 0) begin   // Previous row, now past its sampling edge
                check_flags(flags, rows[i-1].exp_flags, i - 1);
                check_regs(regs, rows[i-1].exp_regs, i - 1);
                check_miss(miss, rows[i-1].exp_miss, i - 1);
                check_lines(nmi_n, int_n, rows[i-1].exp_nmi_n, rows[i-1].exp_int_n, i - 1);
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
